// ==== run_sim.sh ====
#!/bin/sh
# build the model, run it into sim.log, then look for the pass line
rm -f sim.log
verilator --binary --assert -f sim.f --top-module tb_trdb_priority -o tb_trdb_priority \
    && ./obj_dir/tb_trdb_priority > sim.log 2>&1
grep -q "^Result: PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
+incdir+.
trdb_pkg.sv
trdb_cond_decode.sv
trdb_packet_select.sv
trdb_priority.sv
trdb_priority_props.sv
trdb_checker.sv
tb_trdb_priority.sv

// ==== tb_trdb_priority.sv ====
`timescale 1ns/10ps
`include "trdb_consts.svh"

module tb_trdb_priority;

    localparam int MAX_LINES    = 64;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 20;

    logic clk_i;
    logic rst_ni;
    logic valid_i;
    logic lc_exception_i;
    logic lc_updiscon_i;
    logic tc_qualified_i;
    logic tc_exception_i;
    logic tc_retired_i;
    logic tc_first_qualified_i;
    logic tc_privchange_i;
    logic tc_context_change_i;
    logic tc_max_resync_i;
    logic tc_branch_map_empty_i;
    logic tc_branch_map_full_i;
    logic tc_enc_enabled_i;
    logic tc_enc_disabled_i;
    logic tc_opmode_change_i;
    logic lc_final_qualified_i;
    logic nc_exception_i;
    logic nc_privchange_i;
    logic nc_context_change_i;
    logic nc_branch_map_empty_i;
    logic nc_qualified_i;
    logic nc_retired_i;

    logic                             valid_o;
    trdb_pkg::trdb_format_e           packet_format_o;
    trdb_pkg::trdb_f_sync_subformat_e packet_f_sync_subformat_o;
    logic                             thaddr_o;
    logic                             cause_mux_o;
    logic                             tval_mux_o;
    logic                             resync_timer_rst_o;
    trdb_pkg::qual_status_e           qual_status_o;
    logic                             irreport_o;

    // expected values handed to the checker
    logic       exp_valid;
    logic [1:0] exp_format;
    logic [1:0] exp_subformat;
    logic       exp_thaddr;
    logic       exp_cause_mux;
    logic       exp_tval_mux;
    logic       exp_timer_rst;
    logic [1:0] exp_qual_status;
    logic       exp_irreport;

    // one entry per stimulus line
    logic [21:0] stim_in  [MAX_LINES];
    logic [11:0] stim_exp [MAX_LINES];
    int          num_lines;
    int          tb_errors = 0;
    int          checker_errors;
    logic        loaded = 1'b0;

    trdb_priority trdb_priority_inst (.*);

    trdb_checker checker_inst (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .exp_valid_i       (exp_valid),
        .exp_format_i      (exp_format),
        .exp_subformat_i   (exp_subformat),
        .exp_thaddr_i      (exp_thaddr),
        .exp_cause_mux_i   (exp_cause_mux),
        .exp_tval_mux_i    (exp_tval_mux),
        .exp_timer_rst_i   (exp_timer_rst),
        .exp_qual_status_i (exp_qual_status),
        .exp_irreport_i    (exp_irreport),
        .valid_i           (valid_o),
        .format_i          (packet_format_o),
        .subformat_i       (packet_f_sync_subformat_o),
        .thaddr_i          (thaddr_o),
        .cause_mux_i       (cause_mux_o),
        .tval_mux_i        (tval_mux_o),
        .timer_rst_i       (resync_timer_rst_o),
        .qual_status_i     (qual_status_o),
        .irreport_i        (irreport_o),
        .error_count_o     (checker_errors)
    );

    // output rules checked on every dut instance
    bind trdb_priority trdb_priority_props props_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid_o),
        .format_i    (packet_format_o),
        .subformat_i (packet_f_sync_subformat_o),
        .cause_mux_i (cause_mux_o),
        .timer_rst_i (resync_timer_rst_o),
        .irreport_i  (irreport_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // bit order matches the columns of the stimulus file
    task automatic drive_inputs(input logic [21:0] bits, input logic [11:0] exp);
        {valid_i, lc_exception_i, lc_updiscon_i, lc_final_qualified_i,
         tc_qualified_i, tc_exception_i, tc_retired_i, tc_first_qualified_i,
         tc_privchange_i, tc_context_change_i, tc_max_resync_i, tc_branch_map_empty_i,
         tc_branch_map_full_i, tc_enc_enabled_i, tc_enc_disabled_i, tc_opmode_change_i,
         nc_exception_i, nc_privchange_i, nc_context_change_i, nc_branch_map_empty_i,
         nc_qualified_i, nc_retired_i} = bits;
        {exp_valid, exp_format, exp_subformat, exp_thaddr, exp_cause_mux, exp_tval_mux,
         exp_timer_rst, exp_qual_status, exp_irreport} = exp;
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        logic        v;
        logic [2:0]  lc;
        logic [11:0] tc;
        logic [5:0]  nc;
        logic [3:0]  e_valid;
        logic [3:0]  e_fmt;
        logic [3:0]  e_sf;
        logic [3:0]  e_th;
        logic [3:0]  e_cause;
        logic [3:0]  e_tval;
        logic [3:0]  e_trst;
        logic [3:0]  e_qual;
        logic [3:0]  e_irr;
        bit          done;
        num_lines = 0;
        done = 1'b0;
        fd = $fopen("trdb_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file trdb_stim.txt");
            tb_errors++;
        end else begin
            while (!done) begin
                n = $fscanf(fd, "%b %b %b %b %h %h %h %h %h %h %h %h %h\n", v, lc, tc, nc,
                            e_valid, e_fmt, e_sf, e_th, e_cause, e_tval, e_trst, e_qual,
                            e_irr);
                if (n == 13 && num_lines < MAX_LINES) begin
                    stim_in[num_lines]  = {v, lc, tc, nc};
                    stim_exp[num_lines] = {e_valid[0], e_fmt[1:0], e_sf[1:0], e_th[0],
                                           e_cause[0], e_tval[0], e_trst[0], e_qual[1:0],
                                           e_irr[0]};
                    num_lines++;
                end else begin
                    if (n == 13 || n > 0 || (n == 0 && !$feof(fd))) begin
                        $display("stimulus file has a bad or extra line after line %0d",
                                 num_lines);
                        tb_errors++;
                    end
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
        if (num_lines == 0) begin
            $display("no stimulus lines were read");
            tb_errors++;
        end
    endtask

    task automatic finish_run();
        int total;
        total = tb_errors + checker_errors;
        $display("run over: %0d errors (checker %0d, testbench %0d)", total,
                 checker_errors, tb_errors);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        drive_inputs('0, '0);
        rst_ni = 1'b0;
        read_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        // one line per cycle, back to back
        for (int i = 0; i < num_lines; i++) begin
            @(negedge clk_i);
            drive_inputs(stim_in[i], stim_exp[i]);
        end
        // flush the two stages
        repeat (`TRDB_LATENCY + 2) begin
            @(negedge clk_i);
            drive_inputs('0, '0);
        end
        @(posedge clk_i);
        finish_run();
    end

    // watchdog sized from the stimulus length
    initial begin
        wait (loaded);
        #((num_lines + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("timeout, the run did not finish in %0d cycles",
                 num_lines + RESET_CYCLES + 10);
        tb_errors++;
        finish_run();
    end

endmodule

// ==== trdb_checker.sv ====
`timescale 1ns/10ps
`include "trdb_consts.svh"

module trdb_checker (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // expectation for the line driven this cycle
    input  logic                             exp_valid_i,
    input  logic [1:0]                       exp_format_i,
    input  logic [1:0]                       exp_subformat_i,
    input  logic                             exp_thaddr_i,
    input  logic                             exp_cause_mux_i,
    input  logic                             exp_tval_mux_i,
    input  logic                             exp_timer_rst_i,
    input  logic [1:0]                       exp_qual_status_i,
    input  logic                             exp_irreport_i,
    // dut outputs
    input  logic                             valid_i,
    input  trdb_pkg::trdb_format_e           format_i,
    input  trdb_pkg::trdb_f_sync_subformat_e subformat_i,
    input  logic                             thaddr_i,
    input  logic                             cause_mux_i,
    input  logic                             tval_mux_i,
    input  logic                             timer_rst_i,
    input  trdb_pkg::qual_status_e           qual_status_i,
    input  logic                             irreport_i,
    output int                               error_count_o
);

    // valid, format, subformat, thaddr, cause, tval, timer, qual, irreport
    logic [11:0] exp_pipe [`TRDB_LATENCY];
    logic [11:0] exp_out;
    int          errors = 0;

    trdb_pkg::trdb_format_e           exp_format;
    trdb_pkg::trdb_f_sync_subformat_e exp_subformat;
    trdb_pkg::qual_status_e           exp_qual;

    assign error_count_o = errors;
    assign exp_out       = exp_pipe[`TRDB_LATENCY-1];
    assign exp_format    = trdb_pkg::trdb_format_e'(exp_out[10:9]);
    assign exp_subformat = trdb_pkg::trdb_f_sync_subformat_e'(exp_out[8:7]);
    assign exp_qual      = trdb_pkg::qual_status_e'(exp_out[2:1]);

    // delay line in step with the dut stages
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `TRDB_LATENCY; i++) begin
                exp_pipe[i] <= '0;
            end
        end else begin
            exp_pipe[0] <= {exp_valid_i, exp_format_i, exp_subformat_i,
                            exp_thaddr_i, exp_cause_mux_i, exp_tval_mux_i, exp_timer_rst_i,
                            exp_qual_status_i, exp_irreport_i};
            for (int i = 1; i < `TRDB_LATENCY; i++) begin
                exp_pipe[i] <= exp_pipe[i-1];
            end
        end
    end

    task automatic check_field(input string name, input logic [1:0] got,
                               input logic [1:0] expected);
        if (got !== expected) begin
            $display("Error %s expected 0x%0h got 0x%0h at %0t", name, expected, got, $time);
            errors++;
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_field("valid_o", {1'b0, valid_i}, {1'b0, exp_out[11]});
            if (exp_out[11]) begin
                check_field("packet_format_o", format_i, exp_format);
                check_field("packet_f_sync_subformat_o", subformat_i, exp_subformat);
                check_field("thaddr_o", {1'b0, thaddr_i}, {1'b0, exp_out[6]});
                check_field("cause_mux_o", {1'b0, cause_mux_i}, {1'b0, exp_out[5]});
                check_field("tval_mux_o", {1'b0, tval_mux_i}, {1'b0, exp_out[4]});
                check_field("resync_timer_rst_o", {1'b0, timer_rst_i}, {1'b0, exp_out[3]});
                check_field("qual_status_o", qual_status_i, exp_qual);
                check_field("irreport_o", {1'b0, irreport_i}, {1'b0, exp_out[0]});
            end
        end
    end

endmodule

// ==== trdb_cond_decode.sv ====
`timescale 1ns/10ps

module trdb_cond_decode (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic valid_i,
    // last cycle status
    input  logic lc_exception_i,
    input  logic lc_updiscon_i,
    // this cycle status
    input  logic tc_qualified_i,
    input  logic tc_exception_i,
    input  logic tc_retired_i,
    input  logic tc_first_qualified_i,
    input  logic tc_privchange_i,
    input  logic tc_context_change_i,
    input  logic tc_max_resync_i,
    input  logic tc_branch_map_empty_i,
    input  logic tc_branch_map_full_i,
    input  logic tc_enc_enabled_i,
    input  logic tc_enc_disabled_i,
    input  logic tc_opmode_change_i,
    input  logic lc_final_qualified_i,
    // next cycle status
    input  logic nc_exception_i,
    input  logic nc_privchange_i,
    input  logic nc_context_change_i,
    input  logic nc_branch_map_empty_i,
    input  logic nc_qualified_i,
    input  logic nc_retired_i,
    // registered conditions for the select stage
    output logic dec_valid_o,
    output logic dec_f3_sf3_o,
    output logic dec_qualified_o,
    output logic dec_lc_exception_o,
    output logic dec_exc_only_o,
    output logic dec_start_req_o,
    output logic dec_updiscon_o,
    output logic dec_resync_er_o,
    output logic dec_nc_report_o,
    output logic dec_nc_unqualified_o,
    output logic dec_rpt_br_o,
    output logic dec_branch_map_empty_o
);

    logic f3_sf3;
    logic exc_only;
    logic start_req;
    logic resync_er;
    logic nc_exc_only;
    logic nc_ppccd_br;
    logic nc_report;

    // support packet, encoder state changed or qualification just ended
    assign f3_sf3 = tc_enc_enabled_i | tc_enc_disabled_i | tc_opmode_change_i |
                    lc_final_qualified_i;
    // trap with nothing retired
    assign exc_only = tc_exception_i & ~tc_retired_i;
    // new start point needed
    assign start_req = tc_first_qualified_i | tc_privchange_i | tc_context_change_i |
                       tc_max_resync_i;
    // resync with pending branches, or trap after a retirement
    assign resync_er = (tc_max_resync_i & ~tc_branch_map_empty_i) |
                       (tc_exception_i & tc_retired_i);

    // next cycle will need this address reported now
    assign nc_exc_only = nc_exception_i & ~nc_retired_i;
    assign nc_ppccd_br = (nc_privchange_i | nc_context_change_i) & ~nc_branch_map_empty_i;
    assign nc_report   = nc_exc_only | nc_ppccd_br | ~nc_qualified_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_valid_o            <= 1'b0;
            dec_f3_sf3_o           <= 1'b0;
            dec_qualified_o        <= 1'b0;
            dec_lc_exception_o     <= 1'b0;
            dec_exc_only_o         <= 1'b0;
            dec_start_req_o        <= 1'b0;
            dec_updiscon_o         <= 1'b0;
            dec_resync_er_o        <= 1'b0;
            dec_nc_report_o        <= 1'b0;
            dec_nc_unqualified_o   <= 1'b0;
            dec_rpt_br_o           <= 1'b0;
            dec_branch_map_empty_o <= 1'b0;
        end else begin
            dec_valid_o            <= valid_i;
            dec_f3_sf3_o           <= f3_sf3;
            dec_qualified_o        <= tc_qualified_i;
            dec_lc_exception_o     <= lc_exception_i;
            dec_exc_only_o         <= exc_only;
            dec_start_req_o        <= start_req;
            dec_updiscon_o         <= lc_updiscon_i;
            dec_resync_er_o        <= resync_er;
            dec_nc_report_o        <= nc_report;
            dec_nc_unqualified_o   <= ~nc_qualified_i;
            // full map must be flushed
            dec_rpt_br_o           <= tc_branch_map_full_i;
            dec_branch_map_empty_o <= tc_branch_map_empty_i;
        end
    end

endmodule

// ==== trdb_consts.svh ====
`ifndef TRDB_CONSTS_SVH
`define TRDB_CONSTS_SVH

// packet format code, f0 to f3
`define TRDB_FORMAT_W 2

// subformat of a format 3 sync packet
`define TRDB_SUBFORMAT_W 2

// qualification status carried in a support packet
`define TRDB_QUAL_W 2

// cycles from a sample on valid_i to valid_o
// one for the decode stage, one for the select stage
`define TRDB_LATENCY 2

`endif

// ==== trdb_packet_select.sv ====
`timescale 1ns/10ps

module trdb_packet_select (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // decoded conditions from stage 1
    input  logic                             dec_valid_i,
    input  logic                             dec_f3_sf3_i,
    input  logic                             dec_qualified_i,
    input  logic                             dec_lc_exception_i,
    input  logic                             dec_exc_only_i,
    input  logic                             dec_start_req_i,
    input  logic                             dec_updiscon_i,
    input  logic                             dec_resync_er_i,
    input  logic                             dec_nc_report_i,
    input  logic                             dec_nc_unqualified_i,
    input  logic                             dec_rpt_br_i,
    input  logic                             dec_branch_map_empty_i,
    // packet request to the emitter
    output logic                             valid_o,
    output trdb_pkg::trdb_format_e           packet_format_o,
    output trdb_pkg::trdb_f_sync_subformat_e packet_f_sync_subformat_o,
    // 1 when the trap handler address follows the trap
    output logic                             thaddr_o,
    // cause and tval source, 0 last cycle, 1 this cycle
    output logic                             cause_mux_o,
    output logic                             tval_mux_o,
    output logic                             resync_timer_rst_o,
    output trdb_pkg::qual_status_e           qual_status_o,
    output logic                             irreport_o
);

    // last cycle reporting state
    logic reported_d;
    logic reported_q;
    logic ended_ntr_d;
    logic ended_ntr_q;
    logic ended_rep_d;
    logic ended_rep_q;

    // next values of the output register
    logic                             valid_d;
    trdb_pkg::trdb_format_e           format_d;
    trdb_pkg::trdb_f_sync_subformat_e subformat_d;
    logic                             thaddr_d;
    logic                             cause_mux_d;
    logic                             tval_mux_d;
    logic                             timer_rst_d;
    trdb_pkg::qual_status_e           qual_status_d;
    logic                             irreport_d;

    // priority tree, first match wins
    always_comb begin
        valid_d       = 1'b0;
        format_d      = trdb_pkg::F_OPT_EXT;
        subformat_d   = trdb_pkg::SF_START;
        thaddr_d      = 1'b0;
        cause_mux_d   = 1'b0;
        tval_mux_d    = 1'b0;
        timer_rst_d   = 1'b0;
        qual_status_d = trdb_pkg::NO_CHANGE;
        irreport_d    = 1'b0;
        reported_d    = 1'b0;
        ended_ntr_d   = 1'b0;
        ended_rep_d   = 1'b0;

        if (dec_valid_i) begin
            if (dec_f3_sf3_i) begin
                // support packet, ntr wins over rep
                valid_d     = 1'b1;
                format_d    = trdb_pkg::F_SYNC;
                subformat_d = trdb_pkg::SF_SUPPORT;
                if (ended_ntr_q) begin
                    qual_status_d = trdb_pkg::ENDED_NTR;
                end else if (ended_rep_q) begin
                    qual_status_d = trdb_pkg::ENDED_REP;
                end
            end else if (dec_qualified_i) begin
                if (dec_lc_exception_i) begin
                    // trap taken last cycle, selects stay on lc
                    valid_d     = 1'b1;
                    format_d    = trdb_pkg::F_SYNC;
                    timer_rst_d = 1'b1;
                    if (dec_exc_only_i) begin
                        subformat_d = trdb_pkg::SF_TRAP;
                        reported_d  = 1'b1;
                    end else if (reported_q) begin
                        // trap already sent, restart from handler
                        subformat_d = trdb_pkg::SF_START;
                    end else begin
                        subformat_d = trdb_pkg::SF_TRAP;
                        thaddr_d    = 1'b1;
                    end
                end else if (dec_start_req_i) begin
                    valid_d     = 1'b1;
                    format_d    = trdb_pkg::F_SYNC;
                    subformat_d = trdb_pkg::SF_START;
                    timer_rst_d = 1'b1;
                end else if (dec_updiscon_i) begin
                    valid_d     = 1'b1;
                    ended_ntr_d = 1'b1;
                    if (dec_exc_only_i) begin
                        // trap on the target, cause and tval from this cycle
                        format_d    = trdb_pkg::F_SYNC;
                        subformat_d = trdb_pkg::SF_TRAP;
                        timer_rst_d = 1'b1;
                        cause_mux_d = 1'b1;
                        tval_mux_d  = 1'b1;
                    end else begin
                        format_d   = dec_branch_map_empty_i ? trdb_pkg::F_ADDR_ONLY
                                                            : trdb_pkg::F_DIFF_DELTA;
                        irreport_d = dec_updiscon_i;
                    end
                end else if (dec_resync_er_i) begin
                    valid_d    = 1'b1;
                    format_d   = dec_branch_map_empty_i ? trdb_pkg::F_ADDR_ONLY
                                                        : trdb_pkg::F_DIFF_DELTA;
                    irreport_d = dec_updiscon_i;
                end else if (dec_nc_report_i) begin
                    // last qualified instr flags the rep ending
                    valid_d     = 1'b1;
                    format_d    = dec_branch_map_empty_i ? trdb_pkg::F_ADDR_ONLY
                                                         : trdb_pkg::F_DIFF_DELTA;
                    irreport_d  = dec_updiscon_i;
                    ended_rep_d = dec_nc_unqualified_i;
                end else if (dec_rpt_br_i) begin
                    // flush the full branch map
                    valid_d    = 1'b1;
                    format_d   = trdb_pkg::F_DIFF_DELTA;
                    irreport_d = dec_updiscon_i;
                end
            end
        end
    end

    // history flags follow this cycle's decision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reported_q  <= 1'b0;
            ended_ntr_q <= 1'b0;
            ended_rep_q <= 1'b0;
        end else begin
            reported_q  <= reported_d;
            ended_ntr_q <= ended_ntr_d;
            ended_rep_q <= ended_rep_d;
        end
    end

    // output register, second pipeline stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o                   <= 1'b0;
            packet_format_o           <= trdb_pkg::F_OPT_EXT;
            packet_f_sync_subformat_o <= trdb_pkg::SF_START;
            thaddr_o                  <= 1'b0;
            cause_mux_o               <= 1'b0;
            tval_mux_o                <= 1'b0;
            resync_timer_rst_o        <= 1'b0;
            qual_status_o             <= trdb_pkg::NO_CHANGE;
            irreport_o                <= 1'b0;
        end else begin
            valid_o                   <= valid_d;
            packet_format_o           <= format_d;
            packet_f_sync_subformat_o <= subformat_d;
            thaddr_o                  <= thaddr_d;
            cause_mux_o               <= cause_mux_d;
            tval_mux_o                <= tval_mux_d;
            resync_timer_rst_o        <= timer_rst_d;
            qual_status_o             <= qual_status_d;
            irreport_o                <= irreport_d;
        end
    end

endmodule

// ==== trdb_pkg.sv ====
package trdb_pkg;

    `include "trdb_consts.svh"

    // packet format as sent on the trace port
    typedef enum logic [`TRDB_FORMAT_W-1:0] {
        // optional extension, jtc and pbc, unused here
        F_OPT_EXT    = 2'h0,
        // differential address plus branch map
        F_DIFF_DELTA = 2'h1,
        // address only, branch map empty
        F_ADDR_ONLY  = 2'h2,
        // sync packets, see subformat
        F_SYNC       = 2'h3
    } trdb_format_e;

    // subformat of a format 3 packet
    typedef enum logic [`TRDB_SUBFORMAT_W-1:0] {
        // start of trace or resync
        SF_START   = 2'h0,
        // exception or interrupt
        SF_TRAP    = 2'h1,
        // context change, not produced by this encoder
        SF_CONTEXT = 2'h2,
        // encoder status and qualification
        SF_SUPPORT = 2'h3
    } trdb_f_sync_subformat_e;

    // why tracing stopped, reported in a support packet
    typedef enum logic [`TRDB_QUAL_W-1:0] {
        // nothing to report
        NO_CHANGE  = 2'h0,
        // ended after a reported packet
        ENDED_REP  = 2'h1,
        // packets dropped, kept for encoding only
        TRACE_LOST = 2'h2,
        // ended on an uninferable discontinuity
        ENDED_NTR  = 2'h3
    } qual_status_e;

endpackage

// ==== trdb_priority.sv ====
`timescale 1ns/10ps

module trdb_priority (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             valid_i,
    input  logic                             lc_exception_i,
    input  logic                             lc_updiscon_i,
    input  logic                             tc_qualified_i,
    input  logic                             tc_exception_i,
    input  logic                             tc_retired_i,
    input  logic                             tc_first_qualified_i,
    input  logic                             tc_privchange_i,
    input  logic                             tc_context_change_i,
    input  logic                             tc_max_resync_i,
    input  logic                             tc_branch_map_empty_i,
    input  logic                             tc_branch_map_full_i,
    input  logic                             tc_enc_enabled_i,
    input  logic                             tc_enc_disabled_i,
    input  logic                             tc_opmode_change_i,
    input  logic                             lc_final_qualified_i,
    input  logic                             nc_exception_i,
    input  logic                             nc_privchange_i,
    input  logic                             nc_context_change_i,
    input  logic                             nc_branch_map_empty_i,
    input  logic                             nc_qualified_i,
    input  logic                             nc_retired_i,
    output logic                             valid_o,
    output trdb_pkg::trdb_format_e           packet_format_o,
    output trdb_pkg::trdb_f_sync_subformat_e packet_f_sync_subformat_o,
    output logic                             thaddr_o,
    output logic                             cause_mux_o,
    output logic                             tval_mux_o,
    output logic                             resync_timer_rst_o,
    output trdb_pkg::qual_status_e           qual_status_o,
    output logic                             irreport_o
);

    // stage 1 to stage 2 conditions
    logic dec_valid;
    logic dec_f3_sf3;
    logic dec_qualified;
    logic dec_lc_exception;
    logic dec_exc_only;
    logic dec_start_req;
    logic dec_updiscon;
    logic dec_resync_er;
    logic dec_nc_report;
    logic dec_nc_unqualified;
    logic dec_rpt_br;
    logic dec_branch_map_empty;

    // raw core status, names match the top ports
    trdb_cond_decode u_cond_decode (
        .*,
        .dec_valid_o            (dec_valid),
        .dec_f3_sf3_o           (dec_f3_sf3),
        .dec_qualified_o        (dec_qualified),
        .dec_lc_exception_o     (dec_lc_exception),
        .dec_exc_only_o         (dec_exc_only),
        .dec_start_req_o        (dec_start_req),
        .dec_updiscon_o         (dec_updiscon),
        .dec_resync_er_o        (dec_resync_er),
        .dec_nc_report_o        (dec_nc_report),
        .dec_nc_unqualified_o   (dec_nc_unqualified),
        .dec_rpt_br_o           (dec_rpt_br),
        .dec_branch_map_empty_o (dec_branch_map_empty)
    );

    // packet outputs go straight to the top ports
    trdb_packet_select u_packet_select (
        .*,
        .dec_valid_i            (dec_valid),
        .dec_f3_sf3_i           (dec_f3_sf3),
        .dec_qualified_i        (dec_qualified),
        .dec_lc_exception_i     (dec_lc_exception),
        .dec_exc_only_i         (dec_exc_only),
        .dec_start_req_i        (dec_start_req),
        .dec_updiscon_i         (dec_updiscon),
        .dec_resync_er_i        (dec_resync_er),
        .dec_nc_report_i        (dec_nc_report),
        .dec_nc_unqualified_i   (dec_nc_unqualified),
        .dec_rpt_br_i           (dec_rpt_br),
        .dec_branch_map_empty_i (dec_branch_map_empty)
    );

endmodule

// ==== trdb_priority_props.sv ====
`timescale 1ns/10ps

module trdb_priority_props (
    input logic                             clk_i,
    input logic                             rst_ni,
    input logic                             valid_i,
    input trdb_pkg::trdb_format_e           format_i,
    input trdb_pkg::trdb_f_sync_subformat_e subformat_i,
    input logic                             cause_mux_i,
    input logic                             timer_rst_i,
    input logic                             irreport_i
);

    // pipe is empty coming out of reset
    valid_after_reset: assert property (@(posedge clk_i) !rst_ni |=> !valid_i)
        else $error("valid_o was high in the first cycle after reset");

    // only sync packets restart the resync timer
    timer_rst_sync: assert property (@(posedge clk_i) disable iff (!rst_ni)
        timer_rst_i |-> (valid_i && format_i == trdb_pkg::F_SYNC))
        else $error("resync_timer_rst_o without a valid sync packet");

    cause_on_trap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cause_mux_i |-> (subformat_i == trdb_pkg::SF_TRAP))
        else $error("cause_mux_o set outside a trap packet");

    // irreport rides on branch packets only
    irreport_on_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        irreport_i |-> (format_i == trdb_pkg::F_DIFF_DELTA ||
                        format_i == trdb_pkg::F_ADDR_ONLY))
        else $error("irreport_o set on a packet that is not a branch packet");

endmodule

// ==== trdb_stim.txt ====
0 000 000000000000 000000 0 0 0 0 0 0 0 0 0
0 000 100000000100 000010 0 0 0 0 0 0 0 0 0
1 000 100000000000 000010 0 0 0 0 0 0 0 0 0
1 000 100000000100 000010 1 3 3 0 0 0 0 0 0
1 010 100000000000 000010 1 1 0 0 0 0 0 0 1
1 000 100000000001 000010 1 3 3 0 0 0 0 3 0
1 000 100000010000 000000 1 2 0 0 0 0 0 0 0
1 000 100000000010 000010 1 3 3 0 0 0 0 1 0
1 001 000000000000 000010 1 3 3 0 0 0 0 0 0
1 100 000000000000 000010 0 0 0 0 0 0 0 0 0
1 100 110000000000 000010 1 3 1 0 0 0 1 0 0
1 100 100000000000 000010 1 3 0 0 0 0 1 0 0
1 100 100000000000 000010 1 3 1 1 0 0 1 0 0
1 000 100000000000 000010 0 0 0 0 0 0 0 0 0
1 100 111000000000 000010 1 3 1 1 0 0 1 0 0
1 100 110000000000 000010 1 3 1 0 0 0 1 0 0
1 100 110000000000 000010 1 3 1 0 0 0 1 0 0
1 100 100000000000 000010 1 3 0 0 0 0 1 0 0
1 100 110000000000 000010 1 3 1 0 0 0 1 0 0
0 000 100000000000 000010 0 0 0 0 0 0 0 0 0
1 100 100000000000 000010 1 3 1 1 0 0 1 0 0
1 000 100100000000 000010 1 3 0 0 0 0 1 0 0
1 000 100000100000 000010 1 3 0 0 0 0 1 0 0
1 000 100010000000 000010 1 3 0 0 0 0 1 0 0
1 010 110000000000 000010 1 3 1 0 1 1 1 0 0
1 000 100000000100 000010 1 3 3 0 0 0 0 3 0
1 010 100000010000 000010 1 2 0 0 0 0 0 0 1
1 000 111000000000 000010 1 1 0 0 0 0 0 0 0
1 000 111000010000 000010 1 2 0 0 0 0 0 0 0
1 000 100000000000 100010 1 1 0 0 0 0 0 0 0
1 000 100000010000 010010 1 2 0 0 0 0 0 0 0
1 000 100000000000 010110 0 0 0 0 0 0 0 0 0
1 000 100000001000 000010 1 1 0 0 0 0 0 0 0
1 000 100000000000 000000 1 1 0 0 0 0 0 0 0
1 000 100000000000 000010 0 0 0 0 0 0 0 0 0
1 000 100000000100 000010 1 3 3 0 0 0 0 0 0
1 000 100000010000 000000 1 2 0 0 0 0 0 0 0
1 100 110000000100 000010 1 3 3 0 0 0 0 1 0
0 000 000000000000 000000 0 0 0 0 0 0 0 0 0
1 000 100000000000 000010 0 0 0 0 0 0 0 0 0
